//--- common/cart_params.svh
// Cartridge constants: bank slot count, widths, header region field, settle length
`ifndef CART_PARAMS_SVH
`define CART_PARAMS_SVH

//////////////////////////////
// Bank mapper geometry
//////////////////////////////

// Slots in the page-select window
`define CART_BANK_COUNT 8

// One bank selects a 512 KB window
`define CART_BANK_W 5

//////////////////////////////
// ROM header fields
//////////////////////////////

// First region byte of the header
`define CART_HDR_REGION_ADDR 25'h1F0

`define CART_LETTER_JP 8'h4A  // ASCII J
`define CART_LETTER_US 8'h55  // ASCII U

//////////////////////////////
// Region change handling
//////////////////////////////

// Cycles of system reset after a region change
`define CART_SETTLE_DEFAULT 65535

`endif

//--- common/cart_bus_pkg.sv
// Loader beat and CPU page bus types
`default_nettype none

package cart_bus_pkg;

	//////////////////////////////
	// Download side
	//////////////////////////////

	typedef logic [7:0]  load_index_t;  // Loader file index
	typedef logic [24:0] load_addr_t;   // Byte address in the image
	typedef logic [15:0] load_data_t;

	// One loader write, held while wr is high
	typedef struct packed {
		logic        download;  // Level, high for the whole transfer
		logic        wr;        // Write strobe
		load_index_t index;     // Bit 6 marks cart mode
		load_addr_t  addr;
		load_data_t  data;
	} load_beat_t;

	//////////////////////////////
	// 68000 side
	//////////////////////////////

	// Word address, A0 does not exist on the bus
	typedef logic [23:1] cpu_addr_t;
	typedef logic [15:0] cpu_word_t;

	// Page-select window at A130Fx
	typedef struct packed {
		cpu_addr_t va;
		cpu_word_t wdata;
		logic      rnw;        // High on read
		logic      page_ce_n;  // Active low window select
	} page_bus_t;

endpackage

`default_nettype wire

//--- common/cart_map_pkg.sv
// Mapping result types: bank numbers, slots, masks, ROM addresses, region codes
`default_nettype none

`include "cart_params.svh"

package cart_map_pkg;

	typedef logic [`CART_BANK_W-1:0] bank_t;
	typedef logic [$clog2(`CART_BANK_COUNT)-1:0] bank_slot_t;

	// Size mask over address bits 23 to 13
	typedef logic [23:13] rom_mask_t;

	// ROM word address after banking and masking
	typedef logic [22:0] rom_addr_t;

	// Bit 1 set means a PAL system
	typedef logic [1:0] region_t;

	localparam region_t region_jp = 2'd0;
	localparam region_t region_us = 2'd1;
	localparam region_t region_eu = 2'd2;

endpackage

`default_nettype wire

//--- loader/header_scan.sv
// ROM download decode, size mask accumulation, cart mode and header region capture
`timescale 1ns/1ns
`default_nettype none

`include "cart_params.svh"

module header_scan
	import cart_bus_pkg::*;
	import cart_map_pkg::*;
(
	input  wire        clk_sys,
	input  wire        reset,
	input  load_beat_t load,
	output logic       rom_loading,
	output rom_mask_t  rom_mask,
	output logic       cart_mode,
	output region_t    region_req
);

	logic rom_wr;      // Accepted write beat of a ROM image
	logic cart_beat;

	// Index 0 is the BIOS slot, index 1 the cartridge
	assign rom_loading = load.download & (load.index[5:0] <= 6'h01);
	assign rom_wr      = rom_loading & load.wr;
	assign cart_beat   = rom_wr & load.index[6];

	//////////////////////////////
	// Size mask and mode
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_mask  <= '0;
			cart_mode <= 1'b0;
		end else begin
			if (rom_wr)
				cart_mode <= load.index[6];

			if (cart_beat) begin
				// First beat of a new image restarts the mask
				if (load.addr == '0)
					rom_mask <= '0;
				else
					rom_mask <= rom_mask | load.addr[23:13];
			end
		end
	end

	//////////////////////////////
	// Region letter from header
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			region_req <= region_jp;
		end else if (rom_wr && load.addr == `CART_HDR_REGION_ADDR) begin
			if (load.data[7:0] == `CART_LETTER_JP)
				region_req <= region_jp;
			else if (load.data[7:0] == `CART_LETTER_US)
				region_req <= region_us;
			else
				region_req <= region_eu;  // Anything else runs as PAL
		end
	end

endmodule

`default_nettype wire

//--- mapper/bank_regs.sv
// Bank register file with identity reset and a single write port
`timescale 1ns/1ns
`default_nettype none

`include "cart_params.svh"

module bank_regs
	import cart_map_pkg::*;
(
	input  wire        clk_sys,
	input  wire        reset,
	input  wire        rom_loading,
	input  wire        wr_en,
	input  bank_slot_t wr_slot,
	input  bank_t      wr_bank,
	output bank_t      banks [`CART_BANK_COUNT]
);

	// Slot n points at bank n until the game remaps it.
	// A fresh download puts the table back in that order, so a
	// small ROM always sees a flat address space.
	always_ff @(posedge clk_sys) begin
		if (reset || rom_loading) begin
			for (int i = 0; i < `CART_BANK_COUNT; i++)
				banks[i] <= bank_t'(i);
		end else if (wr_en) begin
			banks[wr_slot] <= wr_bank;
		end
	end

endmodule

`default_nettype wire

//--- mapper/rom_mapper.sv
// Page window write decode and registered CPU to ROM address translation
`timescale 1ns/1ns
`default_nettype none

`include "cart_params.svh"

module rom_mapper
	import cart_bus_pkg::*;
	import cart_map_pkg::*;
(
	input  wire        clk_sys,
	input  wire        reset,
	input  page_bus_t  cpu,
	input  rom_mask_t  rom_mask,
	input  bank_t      banks [`CART_BANK_COUNT],
	output logic       wr_en,
	output bank_slot_t wr_slot,
	output bank_t      wr_bank,
	output rom_addr_t  rom_addr
);

	logic      ce_n_d;     // Page select one cycle back
	logic      ce_fall;
	logic      big_rom;    // Over 4 MB
	bank_t     va_bank;
	rom_addr_t banked_addr;

	//////////////////////////////
	// Bank register writes
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset)
			ce_n_d <= 1'b1;  // Window idles deselected
		else
			ce_n_d <= cpu.page_ce_n;
	end

	assign ce_fall = ce_n_d & ~cpu.page_ce_n;
	assign big_rom = |rom_mask[23:22];

	// Slot 0 is fixed, it holds the vectors
	assign wr_en   = ce_fall & ~cpu.rnw & (|cpu.va[3:1]) & big_rom;
	assign wr_slot = cpu.va[3:1];
	assign wr_bank = cpu.wdata[4:0];

	//////////////////////////////
	// Address translation
	//////////////////////////////

	assign va_bank     = banks[cpu.va[21:19]];  // 512 KB window select
	assign banked_addr = {va_bank, cpu.va[18:1]};

	// Mask wraps mirrors of small images, low 12 bits always pass
	always_ff @(posedge clk_sys) begin
		rom_addr <= banked_addr & {rom_mask, 12'hFFF};
	end

endmodule

`default_nettype wire

//--- verilog/region_ctrl.sv
// Region select with menu override, active region register, settle reset timer
`timescale 1ns/1ns
`default_nettype none

module region_ctrl
	import cart_map_pkg::*;
#(
	parameter int settle_cycles = 65535
) (
	input  wire        clk_sys,
	input  wire        reset,
	input  region_t    region_req,
	input  wire  [1:0] region_override,  // 0 auto, else region plus one
	output region_t    region,
	output logic       region_set
);

	localparam int cnt_w = $clog2(settle_cycles + 1);
	localparam logic [cnt_w-1:0] settle_last = cnt_w'(settle_cycles);

	region_t          region_new;
	logic [cnt_w-1:0] settle_cnt;

	assign region_new = (region_override != 2'd0) ? region_t'(region_override - 2'd1)
		: region_req;

	// Hold the system in reset long enough for the new video
	// standard to take over. A change in the middle of a window
	// drops the request for a cycle and starts a full new one.
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			region     <= region_jp;
			settle_cnt <= '0;
			region_set <= 1'b0;
		end else begin
			region <= region_new;
			if (region != region_new) begin
				settle_cnt <= '0;  // Restart window
				region_set <= 1'b0;
			end else if (settle_cnt != settle_last) begin
				settle_cnt <= settle_cnt + 1'b1;
				region_set <= 1'b1;
			end else begin
				region_set <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/cart_top.sv
// Cartridge side top: header scanner, region control, bank registers and mapper
`timescale 1ns/1ns
`default_nettype none

`include "cart_params.svh"

module cart_top
	import cart_bus_pkg::*;
	import cart_map_pkg::*;
#(
	parameter int settle_cycles = `CART_SETTLE_DEFAULT
) (
	input  wire        clk_sys,
	input  wire        reset,
	input  load_beat_t load,
	input  page_bus_t  cpu,
	input  wire  [1:0] region_override,
	output region_t    region,
	output logic       region_set,
	output rom_addr_t  rom_addr,
	output rom_mask_t  rom_mask,
	output logic       cart_mode
);

	logic       rom_loading;
	region_t    region_req;
	logic       wr_en;
	bank_slot_t wr_slot;
	bank_t      wr_bank;
	bank_t      banks [`CART_BANK_COUNT];

	header_scan u_header_scan (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.load        (load),
		.rom_loading (rom_loading),
		.rom_mask    (rom_mask),
		.cart_mode   (cart_mode),
		.region_req  (region_req)
	);

	region_ctrl #(
		.settle_cycles (settle_cycles)
	) u_region_ctrl (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.region_req      (region_req),
		.region_override (region_override),
		.region          (region),
		.region_set      (region_set)
	);

	bank_regs u_bank_regs (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.rom_loading (rom_loading),
		.wr_en       (wr_en),
		.wr_slot     (wr_slot),
		.wr_bank     (wr_bank),
		.banks       (banks)
	);

	rom_mapper u_rom_mapper (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu      (cpu),
		.rom_mask (rom_mask),
		.banks    (banks),
		.wr_en    (wr_en),
		.wr_slot  (wr_slot),
		.wr_bank  (wr_bank),
		.rom_addr (rom_addr)
	);

endmodule

`default_nettype wire

//--- tb/cart_top_sva.sv
// Bound checks on the cartridge top: settle length, mask containment, settle start
`timescale 1ns/1ns
`default_nettype none

module cart_top_sva
	import cart_map_pkg::*;
#(
	parameter int settle_cycles = 16
) (
	input wire            clk_sys,
	input wire            reset,
	input wire region_t   region,
	input wire            region_set,
	input wire rom_addr_t rom_addr,
	input wire rom_mask_t rom_mask
);

	int set_run;  // Edges in a row with region_set high

	always_ff @(posedge clk_sys) begin
		if (reset || !region_set)
			set_run <= 0;
		else
			set_run <= set_run + 1;
	end

	assert property (@(posedge clk_sys) disable iff (reset) set_run <= settle_cycles)
		else $error("region_set high for more than %0d cycles", settle_cycles);

	// rom_addr was built with the mask of the cycle before
	assert property (@(posedge clk_sys) disable iff (reset)
		(rom_addr & ~{$past(rom_mask), 12'hFFF}) == '0)
		else $error("rom_addr has bits outside the ROM mask");

	// Window opens one cycle after the change
	assert property (@(posedge clk_sys) disable iff (reset)
		region != $past(region) |=> region_set)
		else $error("region change without region_set");

endmodule

`default_nettype wire

//--- tb/cart_top_tb.sv
// Cartridge top testbench: clock, reset, directed tests, compare tasks, timeout
`timescale 1ns/1ns
`default_nettype none

`include "cart_params.svh"

module cart_top_tb
	import cart_bus_pkg::*;
	import cart_map_pkg::*;
();

	localparam int settle      = 16;
	localparam int cycle_limit = 2000;  // Tests need about 350

	logic        clk_sys = 1'b0;
	logic        reset;
	load_beat_t  load;
	page_bus_t   cpu;
	logic [1:0]  region_override;
	region_t     region;
	logic        region_set;
	rom_addr_t   rom_addr;
	rom_mask_t   rom_mask;
	logic        cart_mode;

	rom_mask_t   exp_mask;       // Size mask model
	bank_t       exp_banks [8];  // Bank table model
	int          cycles = 0;

	cart_top #(
		.settle_cycles (settle)
	) uut (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.load            (load),
		.cpu             (cpu),
		.region_override (region_override),
		.region          (region),
		.region_set      (region_set),
		.rom_addr        (rom_addr),
		.rom_mask        (rom_mask),
		.cart_mode       (cart_mode)
	);

	bind cart_top cart_top_sva #(
		.settle_cycles (settle_cycles)
	) u_sva (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.region     (region),
		.region_set (region_set),
		.rom_addr   (rom_addr),
		.rom_mask   (rom_mask)
	);

	always #50 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles == cycle_limit) begin
			$display("Timeout: tests still running after %0d cycles", cycle_limit);
			stop_run();
		end
	end

	//////////////////////////////
	// Compare and helper tasks
	//////////////////////////////

	task automatic stop_run();
		$display("*** FAILED ***");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_region(string name, region_t exp, region_t act);
		if (act !== exp) begin
			$display("[FAIL] %0t ns %s expected %0d got %0d", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_addr(string name, rom_addr_t exp, rom_addr_t act);
		if (act !== exp) begin
			$display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_mask(string name, rom_mask_t exp, rom_mask_t act);
		if (act !== exp) begin
			$display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("[FAIL] %0t ns %s expected %b got %b", $time, name, exp, act);
			stop_run();
		end
	endtask

	// Drive and sample point, just past the edge
	task automatic tick();
		@(posedge clk_sys);
		#10;
	endtask

	// One loader beat, outputs valid at the next sample
	task automatic load_write(load_addr_t addr, load_data_t data);
		load.wr   = 1'b1;
		load.addr = addr;
		load.data = data;
		if (load.index[6]) begin
			if (addr == '0)
				exp_mask = '0;
			else
				exp_mask = exp_mask | addr[23:13];
		end
		tick();
		load.wr = 1'b0;
	endtask

	// Fresh cart image, random beats below 4 MB, last beat at top
	task automatic rom_download(int beats, load_addr_t top);
		load.download = 1'b1;
		load.index    = 8'h41;
		load_write('0, 16'h0);
		for (int i = 0; i < beats; i++)
			load_write(load_addr_t'($urandom) & 25'h3F_FFFF | 25'h200, 16'h0);
		load_write(top, 16'h0);
		load.download = 1'b0;
		for (int i = 0; i < 8; i++)
			exp_banks[i] = bank_t'(i);
		tick();
		check_mask("rom_mask", exp_mask, rom_mask);
	endtask

	// Low on the change cycle, then high for the settle length
	task automatic settle_window();
		check_bit("region_set", 1'b0, region_set);
		repeat (settle) begin
			tick();
			check_bit("region_set", 1'b1, region_set);
		end
		tick();
		check_bit("region_set", 1'b0, region_set);
	endtask

	task automatic header_letter(load_data_t letter, region_t exp);
		load_write(`CART_HDR_REGION_ADDR, letter);
		tick();
		check_region("region", exp, region);
		settle_window();
	endtask

	// One address per cycle, slots walked in turn
	task automatic map_check(int count);
		cpu_addr_t va;
		rom_addr_t exp;
		for (int i = 0; i <= count; i++) begin
			if (i > 0)
				check_addr("rom_addr", exp, rom_addr);
			va        = cpu_addr_t'($urandom);
			va[21:19] = 3'(i);
			cpu.va    = va;
			exp       = {exp_banks[va[21:19]], va[18:1]} & {exp_mask, 12'hFFF};
			tick();
		end
	endtask

	task automatic page_write(bank_slot_t slot, bank_t bank);
		logic [23:0] byte_addr;
		byte_addr     = 24'hA130F0 | {20'h0, slot, 1'b0};
		cpu.va        = byte_addr[23:1];
		cpu.wdata     = {11'h0, bank};
		cpu.rnw       = 1'b0;
		cpu.page_ce_n = 1'b0;
		if (slot != '0 && exp_mask[23:22] != 2'b00)
			exp_banks[slot] = bank;
		tick();
		cpu.rnw       = 1'b1;
		cpu.page_ce_n = 1'b1;
		tick();
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic test_reset();
		check_region("region", region_jp, region);
		check_mask("rom_mask", '0, rom_mask);
		check_bit("cart_mode", 1'b0, cart_mode);
		settle_window();
	endtask

	task automatic test_download();
		load.download = 1'b1;
		load.index    = 8'h41;  // Cartridge slot in cart mode
		for (int i = 0; i < 4; i++) begin
			load_write(load_addr_t'($urandom) | 25'h200, 16'h0);
			check_mask("rom_mask", exp_mask, rom_mask);
		end
		check_bit("cart_mode", 1'b1, cart_mode);
		load_write('0, 16'h0);
		check_mask("rom_mask", '0, rom_mask);
		load_write(load_addr_t'($urandom) | 25'h200, 16'h0);
		check_mask("rom_mask", exp_mask, rom_mask);
		header_letter({8'h00, `CART_LETTER_US}, region_us);
		header_letter({8'h00, `CART_LETTER_JP}, region_jp);
		header_letter(16'h0045, region_eu);
		load.index = 8'h01;  // Mode bit clear, mask left alone
		load_write(load_addr_t'($urandom) | 25'h200, 16'h0);
		check_bit("cart_mode", 1'b0, cart_mode);
		check_mask("rom_mask", exp_mask, rom_mask);
		load.download = 1'b0;
	endtask

	task automatic test_override();
		for (int n = 1; n <= 3; n++) begin
			region_override = 2'(n);
			tick();
			check_region("region", region_t'(n - 1), region);
			settle_window();
		end
		region_override = 2'd0;  // Header still asks for EU
		repeat (3) begin
			tick();
			check_region("region", region_eu, region);
			check_bit("region_set", 1'b0, region_set);
		end
	endtask

	task automatic test_small_rom();
		rom_download(6, 25'h20_0000);
		map_check(16);
		for (int s = 1; s < 8; s++)
			page_write(bank_slot_t'(s), bank_t'($urandom));
		map_check(16);
	endtask

	task automatic test_large_rom();
		rom_download(6, 25'hC0_0000);
		for (int s = 1; s < 8; s++)
			page_write(bank_slot_t'(s), bank_t'($urandom));
		page_write(3'd0, 5'd31);  // Vector slot stays fixed
		map_check(24);
		rom_download(6, 25'hC0_0000);
		map_check(24);
	endtask

	initial begin
		void'($urandom(32'ha3cd));
		reset           = 1'b1;
		load            = '0;
		cpu             = '0;
		cpu.rnw         = 1'b1;
		cpu.page_ce_n   = 1'b1;
		region_override = 2'd0;
		exp_mask        = '0;
		repeat (8) tick();
		reset = 1'b0;
		test_reset();
		test_download();
		test_override();
		test_small_rom();
		test_large_rom();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
common/cart_bus_pkg.sv
common/cart_map_pkg.sv
loader/header_scan.sv
mapper/bank_regs.sv
mapper/rom_mapper.sv
verilog/region_ctrl.sv
verilog/cart_top.sv
tb/cart_top_sva.sv
tb/cart_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the cartridge testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Mdir obj_dir \
	--top-module cart_top_tb -f sources.f

# A failing run exits nonzero, the search below decides the result
out=$(./obj_dir/Vcart_top_tb || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
